/* logic/stopwatchPkg.sv */
`default_nettype none

package stopwatchPkg;

    typedef logic [3:0] bcdDigit_t;

    // Time as shown, mm:ss.t
    typedef struct packed {
        bcdDigit_t minTens;
        bcdDigit_t minUnits;
        bcdDigit_t secTens;
        bcdDigit_t secUnits;
        bcdDigit_t tenths;
    } bcdTime_t;

    typedef logic [6:0] segments_t;  // Active low, bit 0 is segment a

    typedef struct packed {
        logic       rs;    // 1 for character data
        logic [7:0] code;
    } lcdCommand_t;

    typedef struct packed {
        logic startStop;
        logic split;
    } buttonEvents_t;

    localparam int recordCount    = 4;
    localparam int lcdTableLength = 38;

    typedef logic [1:0] recordIndex_t;
    typedef bcdTime_t [recordCount-1:0] splitRecords_t;

    typedef enum logic [1:0] {
        lcdIdle,
        lcdIssue,
        lcdWaitDone,
        lcdSettle
    } lcdState_t;

    localparam bcdTime_t upStart   = 20'h00000;
    localparam bcdTime_t upLimit   = 20'h59599;  // 59:59.9
    localparam bcdTime_t downStart = 20'h10000;  // 10:00.0
    localparam bcdTime_t downLimit = 20'h00000;

    // HD44780 instructions
    localparam logic [7:0] lcdFunctionSet = 8'h38;  // 8-bit bus, two lines
    localparam logic [7:0] lcdDisplayOn   = 8'h0C;
    localparam logic [7:0] lcdReturnHome  = 8'h02;
    localparam logic [7:0] lcdEntryMode   = 8'h06;
    localparam logic [7:0] lcdLine1       = 8'h80;
    localparam logic [7:0] lcdLine2       = 8'hC0;

    localparam logic [7:0] charColon = 8'h3A;
    localparam logic [7:0] charPoint = 8'h2E;
    localparam logic [7:0] charSpace = 8'h20;
    localparam logic [7:0] charZero  = 8'h30;  // Digits follow in order

    function automatic segments_t digitToSegments(input bcdDigit_t digit);
        case (digit)
            4'd0: return 7'b1000000;
            4'd1: return 7'b1111001;
            4'd2: return 7'b0100100;
            4'd3: return 7'b0110000;
            4'd4: return 7'b0011001;
            4'd5: return 7'b0010010;
            4'd6: return 7'b0000010;
            4'd7: return 7'b1111000;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0011000;
            default: return 7'b1111111;  // Blank
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/buttonDebounce.sv */
`default_nettype none
`timescale 1ns/1ps

module buttonDebounce #(
    parameter int debounceCycles = 500000
) (
    input  logic iCLK,
    input  logic reset,
    input  logic button,   // Active low
    output logic pressed
);

    localparam int countWidth = $clog2(debounceCycles + 2);
    localparam logic [countWidth-1:0] countLimit = countWidth'(debounceCycles + 1);

    logic [countWidth-1:0] pressCount;
    logic                  stable;
    logic                  stableDelayed;

    // Count low samples, saturating one past the debounce length
    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset) begin
            pressCount <= '0;
            stable     <= 1'b0;
        end else if (button) begin
            pressCount <= '0;  // Released or bounced
            stable     <= 1'b0;
        end else begin
            if (pressCount != countLimit)
                pressCount <= pressCount + 1'b1;
            stable <= (pressCount == countLimit);
        end
    end

    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset) begin
            stableDelayed <= 1'b0;
            pressed       <= 1'b0;
        end else begin
            stableDelayed <= stable;
            pressed       <= stable & ~stableDelayed;  // Rising edge only
        end
    end

endmodule

`default_nettype wire

/* logic/timeCounter.sv */
`default_nettype none
`timescale 1ns/1ps

module timeCounter #(
    parameter int tickDivide = 5000000
) (
    input  logic                        iCLK,
    input  logic                        reset,
    input  logic                        mode,       // High counts up
    input  stopwatchPkg::buttonEvents_t events,
    output stopwatchPkg::bcdTime_t      timeValue,
    output logic                        capture,
    output logic                        refresh
);
    import stopwatchPkg::*;

    localparam int divWidth = $clog2(tickDivide);
    localparam logic [divWidth-1:0] divLast = divWidth'(tickDivide - 1);

    logic [divWidth-1:0] divCount;
    logic                tick;
    logic                running;
    logic                atLimit;

    function automatic bcdTime_t stepUp(input bcdTime_t t);
        bcdTime_t n;
        n = t;
        if (t.tenths != 4'd9) begin
            n.tenths = t.tenths + 4'd1;
        end else begin
            n.tenths = 4'd0;
            if (t.secUnits != 4'd9) begin
                n.secUnits = t.secUnits + 4'd1;
            end else begin
                n.secUnits = 4'd0;
                if (t.secTens != 4'd5) begin
                    n.secTens = t.secTens + 4'd1;
                end else begin
                    n.secTens = 4'd0;
                    if (t.minUnits != 4'd9) begin
                        n.minUnits = t.minUnits + 4'd1;
                    end else begin
                        n.minUnits = 4'd0;
                        n.minTens  = t.minTens + 4'd1;
                    end
                end
            end
        end
        return n;
    endfunction

    // Borrow ripples up through zero digits
    function automatic bcdTime_t stepDown(input bcdTime_t t);
        bcdTime_t n;
        n = t;
        if (t.tenths != 4'd0) begin
            n.tenths = t.tenths - 4'd1;
        end else begin
            n.tenths = 4'd9;
            if (t.secUnits != 4'd0) begin
                n.secUnits = t.secUnits - 4'd1;
            end else begin
                n.secUnits = 4'd9;
                if (t.secTens != 4'd0) begin
                    n.secTens = t.secTens - 4'd1;
                end else begin
                    n.secTens = 4'd5;
                    if (t.minUnits != 4'd0) begin
                        n.minUnits = t.minUnits - 4'd1;
                    end else begin
                        n.minUnits = 4'd9;
                        n.minTens  = t.minTens - 4'd1;
                    end
                end
            end
        end
        return n;
    endfunction

    assign tick    = (divCount == divLast);
    assign atLimit = mode ? (timeValue == upLimit) : (timeValue == downLimit);
    assign capture = events.split;

    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset)
            divCount <= '0;
        else if (tick)
            divCount <= '0;
        else
            divCount <= divCount + 1'b1;
    end

    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset) begin
            timeValue <= mode ? upStart : downStart;
            running   <= 1'b0;
            refresh   <= 1'b0;
        end else begin
            if (events.startStop)
                running <= ~running;
            refresh <= events.split | (events.startStop & running);  // Split or stop
            if (running && tick && !atLimit)
                timeValue <= mode ? stepUp(timeValue) : stepDown(timeValue);
        end
    end

endmodule

`default_nettype wire

/* logic/splitBuffer.sv */
`default_nettype none
`timescale 1ns/1ps

module splitBuffer (
    input  logic                        iCLK,
    input  logic                        reset,
    input  logic                        capture,
    input  stopwatchPkg::bcdTime_t      timeValue,
    output stopwatchPkg::splitRecords_t records
);
    import stopwatchPkg::*;

    localparam recordIndex_t lastEntry = recordIndex_t'(recordCount - 1);

    recordIndex_t writePointer;

    // Ring of split times, oldest overwritten first
    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset) begin
            writePointer <= '0;
            records      <= '0;  // All 00:00.0
        end else if (capture) begin
            records[writePointer] <= timeValue;
            if (writePointer == lastEntry)
                writePointer <= '0;
            else
                writePointer <= writePointer + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/lcdSequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module lcdSequencer #(
    parameter int settleCycles = 262142
) (
    input  logic                        iCLK,
    input  logic                        reset,
    input  logic                        refresh,
    input  stopwatchPkg::splitRecords_t records,
    input  logic                        lcdDone,
    output logic                        lcdStart,
    output stopwatchPkg::lcdCommand_t   lcdCommand
);
    import stopwatchPkg::*;

    localparam int indexWidth  = $clog2(lcdTableLength);
    localparam int settleWidth = $clog2(settleCycles + 1);
    localparam logic [indexWidth-1:0]  lastIndex  = indexWidth'(lcdTableLength - 1);
    localparam logic [settleWidth-1:0] settleLast = settleWidth'(settleCycles - 1);

    lcdState_t              state;
    logic [indexWidth-1:0]  tableIndex;
    logic [settleWidth-1:0] settleCount;
    logic                   pending;     // Refresh seen during a pass
    lcdCommand_t            entry;

    // One character of a record shown as mm:ss.t
    function automatic lcdCommand_t recordChar(input bcdTime_t t, input logic [2:0] offset);
        lcdCommand_t c;
        c.rs = 1'b1;
        case (offset)
            3'd0: c.code = charZero + {4'h0, t.minTens};
            3'd1: c.code = charZero + {4'h0, t.minUnits};
            3'd2: c.code = charColon;
            3'd3: c.code = charZero + {4'h0, t.secTens};
            3'd4: c.code = charZero + {4'h0, t.secUnits};
            3'd5: c.code = charPoint;
            default: c.code = charZero + {4'h0, t.tenths};
        endcase
        return c;
    endfunction

    // Command table, record digits read live
    always_comb begin
        case (tableIndex)
            6'd0:  entry = '{rs: 1'b0, code: lcdFunctionSet};
            6'd1:  entry = '{rs: 1'b0, code: lcdDisplayOn};
            6'd2:  entry = '{rs: 1'b0, code: lcdReturnHome};
            6'd3:  entry = '{rs: 1'b0, code: lcdEntryMode};
            6'd4:  entry = '{rs: 1'b0, code: lcdLine1};
            6'd12, 6'd13,
            6'd29, 6'd30: entry = '{rs: 1'b1, code: charSpace};  // Gap between records
            6'd21: entry = '{rs: 1'b0, code: lcdLine2};
            default: begin
                if (tableIndex < 6'd12)
                    entry = recordChar(records[0], 3'(tableIndex - 6'd5));
                else if (tableIndex < 6'd21)
                    entry = recordChar(records[1], 3'(tableIndex - 6'd14));
                else if (tableIndex < 6'd29)
                    entry = recordChar(records[2], 3'(tableIndex - 6'd22));
                else
                    entry = recordChar(records[3], 3'(tableIndex - 6'd31));
            end
        endcase
    end

    always_ff @(posedge iCLK or negedge reset) begin
        if (!reset) begin
            state       <= lcdIssue;  // First pass starts at once
            tableIndex  <= '0;
            settleCount <= '0;
            pending     <= 1'b0;
            lcdStart    <= 1'b0;
            lcdCommand  <= '0;
        end else begin
            case (state)
                lcdIdle: begin
                    if (pending || refresh) begin
                        tableIndex <= '0;
                        state      <= lcdIssue;
                    end
                end
                lcdIssue: begin
                    lcdCommand <= entry;
                    lcdStart   <= 1'b1;
                    state      <= lcdWaitDone;
                end
                lcdWaitDone: begin
                    // Hold command and strobe until the controller answers
                    if (lcdDone) begin
                        lcdStart    <= 1'b0;
                        settleCount <= '0;
                        state       <= lcdSettle;
                    end
                end
                lcdSettle: begin
                    if (settleCount == settleLast) begin
                        if (tableIndex == lastIndex) begin
                            state <= lcdIdle;
                        end else begin
                            tableIndex <= tableIndex + 1'b1;
                            state      <= lcdIssue;
                        end
                    end else begin
                        settleCount <= settleCount + 1'b1;
                    end
                end
                default: state <= lcdIdle;
            endcase

            if (state == lcdIdle)
                pending <= 1'b0;  // Consumed by the new pass
            else if (refresh)
                pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/stopwatchTop.sv */
`default_nettype none
`timescale 1ns/1ps

module stopwatchTop #(
    parameter int tickDivide     = 5000000,  // 50 MHz to 10 Hz
    parameter int debounceCycles = 500000,
    parameter int settleCycles   = 262142
) (
    input  logic                      iCLK,
    input  logic                      reset,
    input  logic                      mode,
    input  logic                      btnStartStop,
    input  logic                      btnSplit,
    input  logic                      lcdDone,
    output stopwatchPkg::segments_t   segA,
    output stopwatchPkg::segments_t   segB,
    output stopwatchPkg::segments_t   segC,
    output stopwatchPkg::segments_t   segD,
    output stopwatchPkg::segments_t   segE,
    output logic                      segBPoint,
    output logic                      lcdStart,
    output stopwatchPkg::lcdCommand_t lcdCommand
);
    import stopwatchPkg::*;

    buttonEvents_t events;
    bcdTime_t      timeValue;
    splitRecords_t records;
    logic          capture;
    logic          refresh;

    buttonDebounce #(.debounceCycles(debounceCycles)) startStopDebounce (
        .iCLK    (iCLK),
        .reset   (reset),
        .button  (btnStartStop),
        .pressed (events.startStop)
    );

    buttonDebounce #(.debounceCycles(debounceCycles)) splitDebounce (
        .iCLK    (iCLK),
        .reset   (reset),
        .button  (btnSplit),
        .pressed (events.split)
    );

    timeCounter #(.tickDivide(tickDivide)) counter0 (
        .iCLK      (iCLK),
        .reset     (reset),
        .mode      (mode),
        .events    (events),
        .timeValue (timeValue),
        .capture   (capture),
        .refresh   (refresh)
    );

    splitBuffer splits0 (
        .iCLK      (iCLK),
        .reset     (reset),
        .capture   (capture),
        .timeValue (timeValue),
        .records   (records)
    );

    lcdSequencer #(.settleCycles(settleCycles)) lcd0 (
        .iCLK       (iCLK),
        .reset      (reset),
        .refresh    (refresh),
        .records    (records),
        .lcdDone    (lcdDone),
        .lcdStart   (lcdStart),
        .lcdCommand (lcdCommand)
    );

    // Rightmost digit is tenths
    assign segA = digitToSegments(timeValue.tenths);
    assign segB = digitToSegments(timeValue.secUnits);
    assign segC = digitToSegments(timeValue.secTens);
    assign segD = digitToSegments(timeValue.minUnits);
    assign segE = digitToSegments(timeValue.minTens);

    assign segBPoint = 1'b0;  // Point after seconds always lit

endmodule

`default_nettype wire

/* include/stopwatchTbModel.svh */
`ifndef STOPWATCH_TB_MODEL_SVH
`define STOPWATCH_TB_MODEL_SVH

int unsigned lcgState       = 19506;
int          valueErrors    = 0;
int          protocolErrors = 0;
int          timeoutErrors  = 0;
bcdTime_t    expRecords [4];   // Expected split ring
int          expPointer;
lcdCommand_t expTable [38];

// Linear congruential generator returning its upper bits
function automatic int unsigned nextRandom(input int unsigned range);
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) % range;
endfunction

// Active-low patterns with bit 0 as segment a
function automatic segments_t encodeDigit(input bcdDigit_t d);
    segments_t p;
    case (d)
        4'd0: p = 7'b1000000;
        4'd1: p = 7'b1111001;
        4'd2: p = 7'b0100100;
        4'd3: p = 7'b0110000;
        4'd4: p = 7'b0011001;
        4'd5: p = 7'b0010010;
        4'd6: p = 7'b0000010;
        4'd7: p = 7'b1111000;
        4'd8: p = 7'b0000000;
        4'd9: p = 7'b0011000;
        default: p = 7'b1111111;
    endcase
    return p;
endfunction

function automatic bcdDigit_t decodeDigit(input segments_t p);
    bcdDigit_t d;
    d = 4'hF;  // No digit shows this pattern
    for (int i = 0; i < 10; i++) begin
        if (encodeDigit(bcdDigit_t'(i)) == p)
            d = bcdDigit_t'(i);
    end
    return d;
endfunction

function automatic bcdTime_t displayedTime();
    bcdTime_t t;
    t.minTens  = decodeDigit(segE);
    t.minUnits = decodeDigit(segD);
    t.secTens  = decodeDigit(segC);
    t.secUnits = decodeDigit(segB);
    t.tenths   = decodeDigit(segA);
    return t;
endfunction

// One step through a count of tenths that holds at 59:59.9 and 00:00.0
function automatic bcdTime_t stepTime(input bcdTime_t t, input logic up);
    int n;
    bcdTime_t r;
    n = ((int'(t.minTens) * 10 + int'(t.minUnits)) * 60
        + int'(t.secTens) * 10 + int'(t.secUnits)) * 10 + int'(t.tenths);
    if (up && n < 35999)
        n = n + 1;
    else if (!up && n > 0)
        n = n - 1;
    r.tenths   = bcdDigit_t'(n % 10);
    r.secUnits = bcdDigit_t'((n / 10) % 10);
    r.secTens  = bcdDigit_t'((n / 100) % 6);
    r.minUnits = bcdDigit_t'((n / 600) % 10);
    r.minTens  = bcdDigit_t'(n / 6000);
    return r;
endfunction

function automatic lcdCommand_t makeCommand(input logic rs, input logic [7:0] code);
    lcdCommand_t c;
    c.rs   = rs;
    c.code = code;
    return c;
endfunction

// Character k of mm:ss.t
function automatic logic [7:0] textCode(input bcdTime_t t, input int k);
    case (k)
        0: return 8'h30 + {4'h0, t.minTens};
        1: return 8'h30 + {4'h0, t.minUnits};
        2: return 8'h3A;
        3: return 8'h30 + {4'h0, t.secTens};
        4: return 8'h30 + {4'h0, t.secUnits};
        5: return 8'h2E;
        default: return 8'h30 + {4'h0, t.tenths};
    endcase
endfunction

task automatic fillTable();
    int base;
    expTable[0] = makeCommand(1'b0, 8'h38);
    expTable[1] = makeCommand(1'b0, 8'h0C);
    expTable[2] = makeCommand(1'b0, 8'h02);
    expTable[3] = makeCommand(1'b0, 8'h06);
    expTable[4] = makeCommand(1'b0, 8'h80);
    for (int r = 0; r < 4; r++) begin
        base = (r < 2) ? 5 + 9 * r : 22 + 9 * (r - 2);  // Two records per line
        for (int k = 0; k < 7; k++)
            expTable[base + k] = makeCommand(1'b1, textCode(expRecords[r], k));
    end
    expTable[12] = makeCommand(1'b1, 8'h20);
    expTable[13] = makeCommand(1'b1, 8'h20);
    expTable[21] = makeCommand(1'b0, 8'hC0);
    expTable[29] = makeCommand(1'b1, 8'h20);
    expTable[30] = makeCommand(1'b1, 8'h20);
endtask

task automatic checkTime(input string name, input bcdTime_t expected, input bcdTime_t actual);
    if (actual !== expected) begin
        valueErrors++;
        $display("ERROR %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
endtask

task automatic checkSegments(input string name, input segments_t expected,
                             input segments_t actual);
    if (actual !== expected) begin
        valueErrors++;
        $display("ERROR %s: expected %b, actual %b", name, expected, actual);
    end
endtask

task automatic checkCommand(input string name, input lcdCommand_t expected,
                            input lcdCommand_t actual);
    if (actual !== expected) begin
        valueErrors++;
        $display("ERROR %s: expected rs %b code %h, actual rs %b code %h",
                 name, expected.rs, expected.code, actual.rs, actual.code);
    end
endtask

`endif

/* verification/stopwatchTb.sv */
`default_nettype none
`timescale 1ns/1ps

module stopwatchTb;
    import stopwatchPkg::*;

    localparam int tickTb     = 4;
    localparam int debounceTb = 3;
    localparam int settleTb   = 2;

    logic        iCLK;
    logic        reset;
    logic        mode;
    logic        btnStartStop;
    logic        btnSplit;
    logic        lcdDone;
    segments_t   segA;
    segments_t   segB;
    segments_t   segC;
    segments_t   segD;
    segments_t   segE;
    logic        segBPoint;
    logic        lcdStart;
    lcdCommand_t lcdCommand;

    logic        expectRunning;
    logic        runPrev;
    logic        monitorOn;
    bcdTime_t    prevTime;
    lcdCommand_t logged [$];   // Commands seen by the fake controller

    `include "stopwatchTbModel.svh"

    stopwatchTop #(
        .tickDivide     (tickTb),
        .debounceCycles (debounceTb),
        .settleCycles   (settleTb)
    ) dut0 (
        .iCLK         (iCLK),
        .reset        (reset),
        .mode         (mode),
        .btnStartStop (btnStartStop),
        .btnSplit     (btnSplit),
        .lcdDone      (lcdDone),
        .segA         (segA),
        .segB         (segB),
        .segC         (segC),
        .segD         (segD),
        .segE         (segE),
        .segBPoint    (segBPoint),
        .lcdStart     (lcdStart),
        .lcdCommand   (lcdCommand)
    );

    initial iCLK = 1'b0;
    always #50 iCLK = ~iCLK;

    task automatic endRun();
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic applyReset(input logic upMode);
        @(posedge iCLK);
        #5;
        monitorOn     = 1'b0;
        mode          = upMode;
        reset         = 1'b0;
        btnStartStop  = 1'b1;
        btnSplit      = 1'b1;
        expectRunning = 1'b0;
        expPointer    = 0;
        for (int r = 0; r < 4; r++)
            expRecords[r] = '0;
        repeat (8) @(posedge iCLK);
        #5;
        logged.delete();
        reset     = 1'b1;
        prevTime  = displayedTime();
        monitorOn = 1'b1;
    endtask

    // Event lands debounce + 3 edges after the drive and the run flag one edge later
    task automatic pressButton(input logic isSplit, input int unsigned holdCycles);
        @(posedge iCLK);
        #5;
        logged.delete();
        if (isSplit)
            btnSplit = 1'b0;
        else
            btnStartStop = 1'b0;
        repeat (debounceTb + 3) @(posedge iCLK);
        @(negedge iCLK);
        if (isSplit) begin
            expRecords[expPointer] = displayedTime();
            expPointer = (expPointer + 1) % 4;
        end
        @(posedge iCLK);
        #5;
        if (!isSplit)
            expectRunning = ~expectRunning;
        repeat (holdCycles) @(posedge iCLK);
        #5;
        btnSplit     = 1'b1;
        btnStartStop = 1'b1;
        repeat (3 + nextRandom(20)) @(posedge iCLK);
    endtask

    task automatic waitForTime(input bcdTime_t target, input int limit);
        int n;
        n = 0;
        while (displayedTime() !== target && n < limit) begin
            @(negedge iCLK);
            n++;
        end
        if (displayedTime() !== target) begin
            timeoutErrors++;
            $display("Timed out waiting for the display to reach %h", target);
        end
    endtask

    // Idle once the strobe stays low well past the settle gap
    task automatic waitLcdIdle();
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        while (quiet < 16 && n < 4000) begin
            @(negedge iCLK);
            n++;
            if (lcdStart === 1'b1)
                quiet = 0;
            else
                quiet++;
        end
        if (quiet < 16) begin
            timeoutErrors++;
            $display("Timed out waiting for the LCD pass to end");
        end
    endtask

    task automatic checkPass(input string name);
        waitLcdIdle();
        fillTable();
        if (logged.size() != 38) begin
            valueErrors++;
            $display("%s logged %0d LCD commands instead of 38", name, logged.size());
        end else begin
            for (int i = 0; i < 38; i++)
                checkCommand($sformatf("%s entry %0d", name, i), expTable[i], logged[i]);
        end
    endtask

    task automatic runPhase(input logic upMode);
        bcdTime_t startTime;
        bcdTime_t limitTime;
        int       splits;
        startTime = upMode ? 20'h00000 : 20'h10000;
        limitTime = upMode ? 20'h59599 : 20'h00000;
        applyReset(upMode);
        checkTime("reset time", startTime, displayedTime());
        checkSegments("segA after reset", encodeDigit(startTime.tenths), segA);
        checkSegments("segB after reset", encodeDigit(startTime.secUnits), segB);
        checkSegments("segC after reset", encodeDigit(startTime.secTens), segC);
        checkSegments("segD after reset", encodeDigit(startTime.minUnits), segD);
        checkSegments("segE after reset", encodeDigit(startTime.minTens), segE);
        checkPass("first pass");
        pressButton(1'b0, 1 + nextRandom(6));  // Start
        splits = upMode ? 5 + nextRandom(4) : 1 + nextRandom(3);
        for (int i = 0; i < splits; i++) begin
            repeat (20 + nextRandom(180)) @(posedge iCLK);
            pressButton(1'b1, 1 + nextRandom(6));
            checkPass("split pass");
        end
        pressButton(1'b0, 1 + nextRandom(6));  // Stop
        checkPass("stop pass");
        pressButton(1'b0, 1 + nextRandom(6));
        waitForTime(limitTime, upMode ? 150000 : 30000);
        repeat (10 * tickTb) @(posedge iCLK);
        @(negedge iCLK);
        checkTime("limit held", limitTime, displayedTime());
        pressButton(1'b0, 1 + nextRandom(6));
        checkPass("stop at limit pass");
    endtask

    // Every display change is one step and only while running
    initial begin : displayMonitor
        bcdTime_t nowTime;
        runPrev = 1'b0;
        forever begin
            @(negedge iCLK);
            if (monitorOn) begin
                nowTime = displayedTime();
                if (decodeDigit(segA) == 4'hF || decodeDigit(segB) == 4'hF
                    || decodeDigit(segC) == 4'hF || decodeDigit(segD) == 4'hF
                    || decodeDigit(segE) == 4'hF) begin
                    valueErrors++;
                    $display("A segment pattern shows no digit at %0t", $time);
                end
                if (segBPoint !== 1'b0) begin
                    valueErrors++;
                    $display("ERROR segBPoint: expected 0, actual %b", segBPoint);
                end
                if (nowTime !== prevTime) begin
                    if (!runPrev) begin
                        valueErrors++;
                        $display("Display changed while stopped at %0t", $time);
                    end else begin
                        checkTime("count step", stepTime(prevTime, mode), nowTime);
                    end
                end
                prevTime = nowTime;
            end
            runPrev = expectRunning;  // Flag that held at this edge
        end
    end

    // Character controller stand-in answering after 1 to 4 cycles
    initial begin : fakeLcd
        lcdCommand_t held;
        int unsigned delay;
        lcdDone = 1'b0;
        forever begin
            @(negedge iCLK);
            if (lcdStart === 1'b1) begin
                held = lcdCommand;
                logged.push_back(held);
                delay = 1 + nextRandom(4);
                repeat (delay) begin
                    @(posedge iCLK);
                    #5;
                    if (reset === 1'b1 && (lcdStart !== 1'b1 || lcdCommand !== held)) begin
                        protocolErrors++;
                        $display("LCD strobe or command changed before done at %0t", $time);
                    end
                end
                lcdDone = 1'b1;
                @(posedge iCLK);
                #5 lcdDone = 1'b0;
            end
        end
    end

    initial begin : mainFlow
        reset         = 1'b0;
        mode          = 1'b1;
        btnStartStop  = 1'b1;
        btnSplit      = 1'b1;
        expectRunning = 1'b0;
        monitorOn     = 1'b0;
        runPhase(1'b1);
        runPhase(1'b0);
        endRun();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
logic/stopwatchPkg.sv
logic/buttonDebounce.sv
logic/timeCounter.sv
logic/splitBuffer.sv
logic/lcdSequencer.sv
logic/stopwatchTop.sv
verification/stopwatchTb.sv

/* Makefile */
# Verilator build and run for the stopwatch testbench

TOP             ?= stopwatchTb
SIM_DIR         ?= simBuild
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' list.f)
HEADERS := $(wildcard include/*.svh)
BIN     := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f list.f \
		--Mdir $(SIM_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)
